//--- src/uart_pkg.sv
package uart_pkg;

    // System clock and serial line rate
    localparam int CLOCK_FREQ = 10_000_000;
    localparam int BAUD_RATE  = 625_000;

    // Clock cycles spent on each serial bit
    localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;

    // Receiver samples in the middle of the bit
    localparam int SAMPLE_POINT = CLKS_PER_BIT / 2;

    // Width of the per-bit clock counter
    localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);

    // Echo buffer between receiver and transmitter
    localparam int FIFO_DEPTH  = 4;
    localparam int FIFO_ADDR_W = $clog2(FIFO_DEPTH);

    // 8N1 framing
    localparam int DATA_BITS = 8;

endpackage

//--- src/uart_rx.sv
module uart_rx
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 serial_in,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_valid,
    output logic                 frame_error
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                    state;
    logic                         serial_meta;
    logic                         serial_sync;
    logic [BIT_CNT_W-1:0]         clk_cnt;
    logic [$clog2(DATA_BITS)-1:0] bit_idx;
    logic [DATA_BITS-1:0]         shift_reg;
    logic                         at_sample;
    logic                         at_wrap;

    // Line idles high, so the synchronizer resets to 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            serial_meta <= 1'b1;
            serial_sync <= 1'b1;
        end else begin
            serial_meta <= serial_in;
            serial_sync <= serial_meta;
        end
    end

    assign at_sample = (clk_cnt == BIT_CNT_W'(SAMPLE_POINT - 1));
    assign at_wrap   = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= RX_IDLE;
            clk_cnt     <= '0;
            bit_idx     <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            clk_cnt  <= at_wrap ? '0 : clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    // Counter starts at the detected falling edge
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (!serial_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Line back high at mid-bit means a glitch
                    if (at_sample && serial_sync) begin
                        state <= RX_IDLE;
                    end else if (at_wrap) begin
                        state <= RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (at_wrap) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == ($clog2(DATA_BITS))'(DATA_BITS - 1)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    // Leave at mid stop bit to catch a back-to-back start edge
                    if (at_sample) begin
                        if (serial_sync) begin
                            rx_valid <= 1'b1;
                        end else begin
                            frame_error <= 1'b1;
                        end
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && at_sample) begin
            shift_reg <= {serial_sync, shift_reg[DATA_BITS-1:1]};
        end
    end

    assign rx_data = shift_reg;

    // One pulse per frame, frames are far longer than a cycle
    a_rx_valid_single: assert property (
        @(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid
    );

endmodule

//--- src/byte_fifo.sv
module byte_fifo
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [DATA_BITS-1:0] wr_data,
    input  logic                 wr_valid,
    output logic [DATA_BITS-1:0] rd_data,
    output logic                 rd_valid,
    input  logic                 rd_ready,
    output logic                 overrun
);

    logic [DATA_BITS-1:0]   mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic [FIFO_ADDR_W:0]   count;
    logic                   full;
    logic                   do_wr;
    logic                   do_rd;

    assign full     = (count == (FIFO_ADDR_W + 1)'(FIFO_DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    // A write while full is lost, even if a read frees a slot this cycle
    assign do_wr = wr_valid && !full;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            // Pointers wrap on their own since depth is a power of two
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            if (wr_valid && full) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n) count <= (FIFO_ADDR_W + 1)'(FIFO_DEPTH)
    );

    // Occupancy matches the pointer distance modulo the depth
    a_ptr_count_match: assert property (
        @(posedge clk) disable iff (!rst_n)
            FIFO_ADDR_W'(wr_ptr - rd_ptr) == count[FIFO_ADDR_W-1:0]
    );

endmodule

//--- src/uart_tx.sv
module uart_tx
    import uart_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [DATA_BITS-1:0] tx_data,
    input  logic                 tx_valid,
    output logic                 tx_ready,
    input  logic                 tx_hold,
    output logic                 serial_out
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t                    state;
    logic [BIT_CNT_W-1:0]         clk_cnt;
    logic [$clog2(DATA_BITS)-1:0] bit_idx;
    logic [DATA_BITS-1:0]         data_q;
    logic                         fire;
    logic                         at_wrap;

    assign fire    = tx_valid && tx_ready;
    assign at_wrap = (clk_cnt == BIT_CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= TX_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            tx_ready   <= 1'b0;
            serial_out <= 1'b1;
        end else begin
            clk_cnt <= at_wrap ? '0 : clk_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (fire) begin
                        // Start bit goes out on the next cycle
                        tx_ready   <= 1'b0;
                        serial_out <= 1'b0;
                        state      <= TX_START;
                    end else begin
                        tx_ready <= !tx_hold;
                    end
                end
                TX_START: begin
                    if (at_wrap) begin
                        serial_out <= data_q[0];
                        state      <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (at_wrap) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == ($clog2(DATA_BITS))'(DATA_BITS - 1)) begin
                            serial_out <= 1'b1;
                            state      <= TX_STOP;
                        end else begin
                            serial_out <= data_q[bit_idx + 1'b1];
                        end
                    end
                end
                TX_STOP: begin
                    // Ready comes back one cycle after the stop bit
                    if (at_wrap) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            data_q <= tx_data;
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n) (state == TX_IDLE) |-> serial_out
    );

endmodule

//--- src/uart_echo.sv
module uart_echo
    import uart_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic serial_in,
    input  logic tx_hold,
    output logic serial_out,
    output logic overrun,
    output logic frame_error
);

    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_valid;
    logic [DATA_BITS-1:0] tx_data;
    logic                 tx_valid;
    logic                 tx_ready;

    // Serial line in, byte pulses out
    uart_rx i_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .serial_in   (serial_in),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid),
        .frame_error (frame_error)
    );

    // Absorbs bytes while the transmitter is busy or held
    byte_fifo i_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_data  (rx_data),
        .wr_valid (rx_valid),
        .rd_data  (tx_data),
        .rd_valid (tx_valid),
        .rd_ready (tx_ready),
        .overrun  (overrun)
    );

    uart_tx i_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .tx_hold    (tx_hold),
        .serial_out (serial_out)
    );

endmodule

//--- verification/uart_echo_tb.sv
module uart_echo_tb
    import uart_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    SEED         = 32'h1472;
    localparam string TEST_FILE    = "verification/uart_echo_tests.txt";
    localparam int    MAX_BYTES    = 8;
    localparam int    BIT_TIMEOUT  = 40 * CLKS_PER_BIT;
    localparam int    DRIVE_LIMIT  = (MAX_BYTES + 1) * BIT_TIMEOUT;
    localparam int    QUIET_CYCLES = 12 * CLKS_PER_BIT;

    logic clk = 1'b0;
    logic rst_n;
    logic serial_in;
    logic tx_hold;
    wire  serial_out;
    wire  overrun;
    wire  frame_error;

    // Current test vector
    string                test_name;
    int                   hold_flag;
    int                   bad_flag;
    int                   n_bytes;
    int                   exp_overrun;
    int                   exp_frame_error;
    logic [DATA_BITS-1:0] stim [MAX_BYTES];
    logic [DATA_BITS-1:0] exp_q [$];
    logic                 drive_done;

    always #50 clk = ~clk;

    uart_echo i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .serial_in   (serial_in),
        .tx_hold     (tx_hold),
        .serial_out  (serial_out),
        .overrun     (overrun),
        .frame_error (frame_error)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else
            report_failure($sformatf("[FAIL] %s %s expected %0h actual %0h",
                                     name, what, exp, act));
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n     = 1'b0;
        serial_in = 1'b1;
        tx_hold   = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
    endtask

    // 8N1 frame, LSB first, called right after a falling clock edge
    task automatic send_frame(input logic [DATA_BITS-1:0] data, input logic bad_stop);
        serial_in = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < DATA_BITS; i++) begin
            serial_in = data[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        serial_in = !bad_stop;
        repeat (CLKS_PER_BIT) @(negedge clk);
        serial_in = 1'b1;
    endtask

    task automatic drive_bytes();
        int gap;
        for (int i = 0; i < n_bytes; i++) begin
            send_frame(stim[i], (bad_flag != 0) && (i == 0));
            // Give the receiver time to drop out of a broken frame
            if ((bad_flag != 0) && (i == 0)) begin
                repeat (2 * CLKS_PER_BIT) @(negedge clk);
            end
            gap = $urandom % 4;
            repeat (gap * CLKS_PER_BIT) @(negedge clk);
        end
        drive_done = 1'b1;
    endtask

    // Finds the start edge, then samples every bit at its middle
    task automatic receive_frame(output logic [DATA_BITS-1:0] data);
        int waited;
        waited = 0;
        while (serial_out !== 1'b0) begin
            @(negedge clk);
            waited++;
            assert (waited <= BIT_TIMEOUT) else
                report_failure($sformatf("Timeout in %s waiting for a start bit on serial_out",
                                         test_name));
        end
        repeat (SAMPLE_POINT) @(negedge clk);
        assert (serial_out === 1'b0) else
            report_failure($sformatf("Start bit on serial_out in %s went high before its middle",
                                     test_name));
        for (int i = 0; i < DATA_BITS; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data[i] = serial_out;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value(test_name, "stop bit", 32'd1, 32'(serial_out));
    endtask

    task automatic collect_echoes();
        logic [DATA_BITS-1:0] got;
        for (int i = 0; i < exp_q.size(); i++) begin
            receive_frame(got);
            check_value(test_name, $sformatf("echo %0d", i), 32'(exp_q[i]), 32'(got));
        end
    endtask

    // Line must stay idle while tx_hold keeps the transmitter parked
    task automatic watch_idle_line();
        int waited;
        waited = 0;
        while (!drive_done) begin
            assert (serial_out === 1'b1) else
                report_failure($sformatf("serial_out left idle in %s while tx_hold was high",
                                         test_name));
            @(negedge clk);
            waited++;
            assert (waited <= DRIVE_LIMIT) else
                report_failure($sformatf("Timeout in %s waiting for the serial driver",
                                         test_name));
        end
    endtask

    task automatic check_quiet_line();
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (serial_out === 1'b1) else
                report_failure($sformatf("Unexpected extra frame on serial_out in %s",
                                         test_name));
        end
    endtask

    // Bytes echo in order, a bad first frame is lost, a held FIFO keeps only its depth
    task automatic build_expected();
        exp_q.delete();
        for (int i = 0; i < n_bytes; i++) begin
            if (!((bad_flag != 0) && (i == 0))) begin
                if ((hold_flag == 0) || (exp_q.size() < FIFO_DEPTH)) begin
                    exp_q.push_back(stim[i]);
                end
            end
        end
    endtask

    task automatic run_test();
        build_expected();
        apply_reset();
        check_value(test_name, "serial_out after reset", 32'd1, 32'(serial_out));
        check_value(test_name, "overrun after reset", 32'd0, 32'(overrun));
        check_value(test_name, "frame_error after reset", 32'd0, 32'(frame_error));
        drive_done = 1'b0;
        tx_hold    = (hold_flag != 0);
        if (hold_flag != 0) begin
            fork
                drive_bytes();
                watch_idle_line();
            join
            tx_hold = 1'b0;
            collect_echoes();
        end else begin
            fork
                drive_bytes();
                collect_echoes();
            join
        end
        check_quiet_line();
        check_value(test_name, "overrun", 32'(exp_overrun), 32'(overrun));
        check_value(test_name, "frame_error", 32'(exp_frame_error), 32'(frame_error));
        $display("Test %s done, %0d bytes echoed", test_name, exp_q.size());
    endtask

    initial begin
        int    fd;
        int    fields;
        string line;
        rst_n      = 1'b0;
        serial_in  = 1'b1;
        tx_hold    = 1'b0;
        drive_done = 1'b0;
        void'($urandom(SEED));
        fd = $fopen(TEST_FILE, "r");
        assert (fd != 0) else
            report_failure($sformatf("Could not open test vector file %s", TEST_FILE));
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %d %d %d %h %h %h %h %h %h %h %h %d %d",
                             test_name, hold_flag, bad_flag, n_bytes,
                             stim[0], stim[1], stim[2], stim[3],
                             stim[4], stim[5], stim[6], stim[7],
                             exp_overrun, exp_frame_error);
            assert (fields == 14 && n_bytes >= 1 && n_bytes <= MAX_BYTES) else
                report_failure($sformatf("Malformed test vector line %s", line));
            run_test();
        end
        $fclose(fd);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- verification/uart_echo_tests.txt
# name hold bad_stop count b0 b1 b2 b3 b4 b5 b6 b7 overrun frame_error
# Bytes in hex, unused byte columns hold 00
# A bad stop bit applies to the first byte only
single_00    0 0 1 00 00 00 00 00 00 00 00 0 0
single_ff    0 0 1 ff 00 00 00 00 00 00 00 0 0
single_55    0 0 1 55 00 00 00 00 00 00 00 0 0
single_a5    0 0 1 a5 00 00 00 00 00 00 00 0 0
stream_8     0 0 8 12 34 56 78 9a bc de f0 0 0
stream_alt   0 0 8 01 80 7e e7 00 ff 3c c3 0 0
hold_4       1 0 4 11 22 33 44 00 00 00 00 0 0
hold_3       1 0 3 c0 ff ee 00 00 00 00 00 0 0
overrun_6    1 0 6 a1 b2 c3 d4 e5 f6 00 00 1 0
after_ovr    0 0 1 5a 00 00 00 00 00 00 00 0 0
overrun_8    1 0 8 10 20 30 40 50 60 70 80 1 0
frame_err    0 1 2 3c 96 00 00 00 00 00 00 0 1
after_ferr   0 0 1 69 00 00 00 00 00 00 00 0 0
frame_err_2  0 1 3 ff 0f f0 00 00 00 00 00 0 1
stream_tail  0 0 5 de ad be ef 42 00 00 00 0 0

//--- flist.f
src/uart_pkg.sv
src/uart_rx.sv
src/byte_fifo.sv
src/uart_tx.sv
src/uart_echo.sv
verification/uart_echo_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the UART echo testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f flist.f --top-module uart_echo_tb \
    -Mdir obj_dir -o sim_uart_echo
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_uart_echo > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
